// File: source/gbCpu_defines.svh
`ifndef GBCPU_DEFINES_SVH
`define GBCPU_DEFINES_SVH

// --------------------
// Datapath widths
`define DATA_WIDTH 8
`define ADDR_WIDTH 16
`define UPC_WIDTH  6

`define RESET_PC 16'h0000

// --------------------
// Microcode ROM entry points
`define FLOW_NOP   6'd0
`define FLOW_LDRN  6'd1   // Two entries
`define FLOW_ALURR 6'd3
`define FLOW_INC16 6'd4
`define FLOW_DEC16 6'd5
`define FLOW_STHLA 6'd6   // Three entries
`define FLOW_JP    6'd9   // Four entries

`endif

// File: source/cpuIsaPkg.sv
`default_nettype none
`include "gbCpu_defines.svh"

package cpuIsaPkg;

  // Codes 0..7 line up with the Z80 register field where 6 is (HL)
  typedef enum logic [4:0] {
    B       = 5'd0,
    C       = 5'd1,
    D       = 5'd2,
    E       = 5'd3,
    H       = 5'd4,
    L       = 5'd5,
    A       = 5'd7,
    BC      = 5'd8,   // Pairs 8..11 follow opcode bits [5:4]
    DE      = 5'd9,
    HL      = 5'd10,
    SP      = 5'd11,
    PC      = 5'd12,
    W       = 5'd13,
    Z       = 5'd14,
    WZ      = 5'd15,
    NULLREG = 5'd31   // Operand taken from the opcode
  } regCode_e;

  typedef struct packed {
    logic [1:0] group;
    logic [2:0] aluOp;
    logic [2:0] src;
  } aluView_t;

  typedef struct packed {
    logic [1:0] group;
    logic [2:0] dst;
    logic [2:0] src;
  } loadView_t;

  typedef union packed {
    logic [`DATA_WIDTH-1:0] raw;
    aluView_t aluView;
    loadView_t loadView;
  } opcodeWord_u;

endpackage

`default_nettype wire

// File: source/uopPkg.sv
`default_nettype none
`include "gbCpu_defines.svh"

package uopPkg;

  typedef logic [`UPC_WIDTH-1:0] upc_t;

  // --------------------
  // Micro-op commands
  typedef enum logic [4:0] {
    nop   = 5'd0,
    sma   = 5'd1,   // Set memory address select
    srm   = 5'd2,   // Register from memory
    smw   = 5'd3,   // Memory write
    inc16 = 5'd4,
    dec16 = 5'd5,
    z80op = 5'd6,   // Register op decoded from the opcode
    spc   = 5'd7    // Load PC
  } uopCmd_e;

  typedef struct packed {
    logic incPc;
    logic endFlow;
    uopCmd_e cmd;
    cpuIsaPkg::regCode_e operand;
  } uop_t;

  // --------------------
  // Flow sequencer
  typedef enum logic [1:0] {
    AFTER_RESET = 2'd0,
    START_FLOW  = 2'd1,
    RUN_FLOW    = 2'd2,
    END_FLOW    = 2'd3
  } seqState_e;

endpackage

`default_nettype wire

// File: source/regFileIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regFileIf;
  cpuIsaPkg::regCode_e readSel;
  cpuIsaPkg::regCode_e writeSel;
  logic [15:0] writeData;
  logic writeEnable;
  logic addrSelLoad;   // Address select takes readSel
  logic incPc;
  logic loadPc;        // PC takes writeData
  logic [15:0] readData;
  logic [7:0] accumulator;

  modport exec (
    output readSel, writeSel, writeData, writeEnable, addrSelLoad, incPc, loadPc,
    input readData, accumulator
  );

  modport regs (
    input readSel, writeSel, writeData, writeEnable, addrSelLoad, incPc, loadPc,
    output readData, accumulator
  );
endinterface

`default_nettype wire

// File: source/ucodeRom.sv
`timescale 1ns/1ps
`default_nettype none
`include "gbCpu_defines.svh"

module ucodeRom (
  input wire uopPkg::upc_t upc,
  input wire [`DATA_WIDTH-1:0] opcode,
  output uopPkg::uop_t uop,
  output uopPkg::upc_t flowIdx
);

  cpuIsaPkg::opcodeWord_u op;

  assign op = opcode;

  function automatic uopPkg::uop_t mkUop(input logic incPc, input logic endFlow,
                                         input uopPkg::uopCmd_e cmd,
                                         input cpuIsaPkg::regCode_e operand);
    mkUop = {incPc, endFlow, cmd, operand};
  endfunction

  // --------------------
  // Micro-program
  always_comb
  begin
    case (upc)
      `FLOW_NOP:       uop = mkUop(1'b1, 1'b1, uopPkg::nop, cpuIsaPkg::NULLREG);
      `FLOW_LDRN:      uop = mkUop(1'b1, 1'b0, uopPkg::nop, cpuIsaPkg::NULLREG);
      `FLOW_LDRN + 1:  uop = mkUop(1'b1, 1'b1, uopPkg::srm, cpuIsaPkg::NULLREG);
      `FLOW_ALURR:     uop = mkUop(1'b1, 1'b1, uopPkg::z80op, cpuIsaPkg::NULLREG);
      `FLOW_INC16:     uop = mkUop(1'b1, 1'b1, uopPkg::inc16, cpuIsaPkg::NULLREG);
      `FLOW_DEC16:     uop = mkUop(1'b1, 1'b1, uopPkg::dec16, cpuIsaPkg::NULLREG);
      `FLOW_STHLA:     uop = mkUop(1'b0, 1'b0, uopPkg::sma, cpuIsaPkg::HL);
      `FLOW_STHLA + 1: uop = mkUop(1'b0, 1'b0, uopPkg::smw, cpuIsaPkg::A);
      `FLOW_STHLA + 2: uop = mkUop(1'b1, 1'b1, uopPkg::sma, cpuIsaPkg::PC);
      `FLOW_JP:        uop = mkUop(1'b1, 1'b0, uopPkg::nop, cpuIsaPkg::NULLREG);
      `FLOW_JP + 1:    uop = mkUop(1'b1, 1'b0, uopPkg::srm, cpuIsaPkg::Z);  // Low byte
      `FLOW_JP + 2:    uop = mkUop(1'b0, 1'b0, uopPkg::srm, cpuIsaPkg::W);
      `FLOW_JP + 3:    uop = mkUop(1'b0, 1'b1, uopPkg::spc, cpuIsaPkg::WZ);
      default:         uop = mkUop(1'b0, 1'b1, uopPkg::nop, cpuIsaPkg::NULLREG);
    endcase
  end

  // Opcode to flow lookup with the (HL) field 110 left out
  always_comb
  begin
    flowIdx = `FLOW_NOP;
    if (opcode == 8'h77)
      flowIdx = `FLOW_STHLA;
    else if (opcode == 8'hC3)
      flowIdx = `FLOW_JP;
    else if (op.loadView.group == 2'b01 && op.loadView.dst != 3'b110 &&
             op.loadView.src != 3'b110)
      flowIdx = `FLOW_ALURR;
    else if (op.aluView.group == 2'b10 && op.aluView.aluOp inside {3'b100, 3'b101, 3'b110} &&
             op.aluView.src != 3'b110)
      flowIdx = `FLOW_ALURR;
    else if (op.loadView.group == 2'b00 && op.loadView.src == 3'b110 &&
             op.loadView.dst != 3'b110)
      flowIdx = `FLOW_LDRN;
    else if (op.loadView.group == 2'b00 && op.raw[3:0] == 4'h3)
      flowIdx = `FLOW_INC16;
    else if (op.loadView.group == 2'b00 && op.raw[3:0] == 4'hB)
      flowIdx = `FLOW_DEC16;
  end

endmodule

`default_nettype wire

// File: source/microSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "gbCpu_defines.svh"

module microSequencer (
  input wire iClock,
  input wire rst,
  input wire endFlow,
  input wire uopPkg::upc_t flowIdx,
  input wire [`DATA_WIDTH-1:0] mcuDataIn,
  output uopPkg::upc_t upc,
  output logic flowActive,
  output cpuIsaPkg::opcodeWord_u curOpcode
);

  uopPkg::seqState_e state;
  uopPkg::seqState_e nextState;

  // --------------------
  // Flow state machine
  always_ff @(posedge iClock)
  begin
    if (rst)
      state <= uopPkg::AFTER_RESET;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      uopPkg::AFTER_RESET: nextState = uopPkg::START_FLOW;
      uopPkg::START_FLOW:  nextState = uopPkg::RUN_FLOW;
      uopPkg::RUN_FLOW:    nextState = endFlow ? uopPkg::END_FLOW : uopPkg::RUN_FLOW;
      uopPkg::END_FLOW:    nextState = uopPkg::START_FLOW;
      default:             nextState = uopPkg::AFTER_RESET;
    endcase
  end

  assign flowActive = (state == uopPkg::RUN_FLOW);

  always_ff @(posedge iClock)
  begin
    if (rst)
      upc <= `FLOW_NOP;
    else if (state == uopPkg::START_FLOW)
      upc <= flowIdx;                  // Flow entry from the fetched byte
    else if (flowActive)
      upc <= upc + 1'b1;
  end

  // Opcode stays put for the rest of the flow
  always_ff @(posedge iClock)
  begin
    if (state == uopPkg::START_FLOW)
      curOpcode <= mcuDataIn;
  end

  flowEndsAssert: assert property (@(posedge iClock) disable iff (rst)
    (state == uopPkg::RUN_FLOW && endFlow) |=> (state == uopPkg::END_FLOW))
    else $error("Flow did not close after endFlow");

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "gbCpu_defines.svh"

module regFile (
  input wire iClock,
  input wire rst,
  regFileIf.regs regs,
  output logic [`ADDR_WIDTH-1:0] mcuAddr
);

  localparam int PadWidth = `ADDR_WIDTH - `DATA_WIDTH;
  localparam logic [`ADDR_WIDTH-1:0] SpReset = 16'hFFFE;

  logic [`DATA_WIDTH-1:0] regB, regC, regD, regE, regH, regL, regA;
  logic [`DATA_WIDTH-1:0] regW, regZ;
  logic [`DATA_WIDTH-1:0] lowByte;
  logic [`ADDR_WIDTH-1:0] sp;
  logic [`ADDR_WIDTH-1:0] pc;
  cpuIsaPkg::regCode_e addrSel;

  assign lowByte = regs.writeData[`DATA_WIDTH-1:0];
  assign regs.accumulator = regA;

  function automatic logic [`ADDR_WIDTH-1:0] regValue(input cpuIsaPkg::regCode_e code);
    case (code)
      cpuIsaPkg::B:  regValue = {{PadWidth{1'b0}}, regB};
      cpuIsaPkg::C:  regValue = {{PadWidth{1'b0}}, regC};
      cpuIsaPkg::D:  regValue = {{PadWidth{1'b0}}, regD};
      cpuIsaPkg::E:  regValue = {{PadWidth{1'b0}}, regE};
      cpuIsaPkg::H:  regValue = {{PadWidth{1'b0}}, regH};
      cpuIsaPkg::L:  regValue = {{PadWidth{1'b0}}, regL};
      cpuIsaPkg::A:  regValue = {{PadWidth{1'b0}}, regA};
      cpuIsaPkg::W:  regValue = {{PadWidth{1'b0}}, regW};
      cpuIsaPkg::Z:  regValue = {{PadWidth{1'b0}}, regZ};
      cpuIsaPkg::BC: regValue = {regB, regC};
      cpuIsaPkg::DE: regValue = {regD, regE};
      cpuIsaPkg::HL: regValue = {regH, regL};
      cpuIsaPkg::WZ: regValue = {regW, regZ};
      cpuIsaPkg::SP: regValue = sp;
      cpuIsaPkg::PC: regValue = pc;
      default:       regValue = '0;
    endcase
  endfunction

  always_comb
  begin
    regs.readData = regValue(regs.readSel);
    mcuAddr = regValue(addrSel);
  end

  always_ff @(posedge iClock)
  begin
    if (regs.writeEnable)
    begin
      case (regs.writeSel)
        cpuIsaPkg::B:  regB <= lowByte;
        cpuIsaPkg::C:  regC <= lowByte;
        cpuIsaPkg::D:  regD <= lowByte;
        cpuIsaPkg::E:  regE <= lowByte;
        cpuIsaPkg::H:  regH <= lowByte;
        cpuIsaPkg::L:  regL <= lowByte;
        cpuIsaPkg::A:  regA <= lowByte;
        cpuIsaPkg::W:  regW <= lowByte;
        cpuIsaPkg::Z:  regZ <= lowByte;
        cpuIsaPkg::BC: {regB, regC} <= regs.writeData;
        cpuIsaPkg::DE: {regD, regE} <= regs.writeData;
        cpuIsaPkg::HL: {regH, regL} <= regs.writeData;
        cpuIsaPkg::WZ: {regW, regZ} <= regs.writeData;
        default: ;
      endcase
    end
  end

  // PC, SP and the address select
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      pc <= `RESET_PC;
      sp <= SpReset;
      addrSel <= cpuIsaPkg::PC;
    end
    else
    begin
      if (regs.loadPc)
        pc <= regs.writeData;
      else if (regs.incPc)
        pc <= pc + 1'b1;
      if (regs.writeEnable && regs.writeSel == cpuIsaPkg::SP)
        sp <= regs.writeData;
      if (regs.addrSelLoad)
        addrSel <= regs.readSel;
    end
  end

  pcCtrlAssert: assert property (@(posedge iClock) disable iff (rst)
    !(regs.loadPc && regs.incPc))
    else $error("PC load and increment in the same cycle");

endmodule

`default_nettype wire

// File: source/uopExecute.sv
`timescale 1ns/1ps
`default_nettype none
`include "gbCpu_defines.svh"

module uopExecute (
  input wire iClock,
  input wire rst,
  input wire uopPkg::uop_t uop,
  input wire flowActive,
  input wire cpuIsaPkg::opcodeWord_u curOpcode,
  input wire [`DATA_WIDTH-1:0] mcuDataIn,
  regFileIf.exec regs,
  output logic [`DATA_WIDTH-1:0] mcuDataOut,
  output logic mcuWe,
  output logic mcuReadRequest
);

  localparam int PadWidth = `ADDR_WIDTH - `DATA_WIDTH;

  cpuIsaPkg::regCode_e operandReg;
  cpuIsaPkg::regCode_e srcReg;
  cpuIsaPkg::regCode_e dstReg;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic readReqQ;

  assign srcReg = cpuIsaPkg::regCode_e'({2'b00, curOpcode.aluView.src});
  assign dstReg = cpuIsaPkg::regCode_e'({2'b00, curOpcode.loadView.dst});

  // NULLREG operand resolves from the opcode
  always_comb
  begin
    if (uop.operand != cpuIsaPkg::NULLREG)
      operandReg = uop.operand;
    else if (uop.cmd inside {uopPkg::inc16, uopPkg::dec16})
      operandReg = cpuIsaPkg::regCode_e'({3'b010, curOpcode.loadView.dst[2:1]});  // BC..SP
    else
      operandReg = dstReg;
  end

  // --------------------
  // Logic ops against A
  always_comb
  begin
    case (curOpcode.aluView.aluOp)
      3'b100:  aluResult = regs.accumulator & regs.readData[`DATA_WIDTH-1:0];
      3'b101:  aluResult = regs.accumulator ^ regs.readData[`DATA_WIDTH-1:0];
      3'b110:  aluResult = regs.accumulator | regs.readData[`DATA_WIDTH-1:0];
      default: aluResult = regs.accumulator;
    endcase
  end

  // --------------------
  // Micro-op decode
  always_comb
  begin
    regs.readSel = operandReg;
    regs.writeSel = operandReg;
    regs.writeData = regs.readData;
    regs.writeEnable = 1'b0;
    regs.addrSelLoad = 1'b0;
    regs.incPc = flowActive && uop.incPc;
    regs.loadPc = 1'b0;
    mcuWe = 1'b0;
    if (flowActive)
    begin
      case (uop.cmd)
        uopPkg::sma: regs.addrSelLoad = 1'b1;
        uopPkg::srm:
        begin
          regs.writeData = {{PadWidth{1'b0}}, mcuDataIn};
          regs.writeEnable = 1'b1;
        end
        uopPkg::smw: mcuWe = 1'b1;
        uopPkg::inc16:
        begin
          regs.writeData = regs.readData + 1'b1;   // Carry crosses into the high byte
          regs.writeEnable = 1'b1;
        end
        uopPkg::dec16:
        begin
          regs.writeData = regs.readData - 1'b1;
          regs.writeEnable = 1'b1;
        end
        uopPkg::spc: regs.loadPc = 1'b1;
        uopPkg::z80op:
        begin
          regs.readSel = srcReg;
          if (curOpcode.loadView.group == 2'b01)
          begin
            regs.writeSel = dstReg;
            regs.writeEnable = 1'b1;
          end
          else if (curOpcode.aluView.group == 2'b10)
          begin
            regs.writeSel = cpuIsaPkg::A;
            regs.writeData = {{PadWidth{1'b0}}, aluResult};
            regs.writeEnable = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign mcuDataOut = regs.readData[`DATA_WIDTH-1:0];

  // Only an address select back to PC starts a read
  always_ff @(posedge iClock)
  begin
    if (rst)
      readReqQ <= 1'b0;
    else
      readReqQ <= flowActive && uop.cmd == uopPkg::sma && uop.operand == cpuIsaPkg::PC;
  end

  assign mcuReadRequest = readReqQ;

  busExclusiveAssert: assert property (@(posedge iClock) disable iff (rst)
    mcuWe |-> !mcuReadRequest)
    else $error("Write strobe during read request");

endmodule

`default_nettype wire

// File: source/gbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module gbCpu (
  input wire iClock,
  input wire rst,
  input wire [7:0] mcuDataIn,
  output logic [7:0] mcuDataOut,
  output logic [15:0] mcuAddr,
  output logic mcuReadRequest,
  output logic mcuWe
);

  uopPkg::upc_t upc;
  uopPkg::upc_t flowIdx;
  uopPkg::uop_t uop;
  logic flowActive;
  cpuIsaPkg::opcodeWord_u curOpcode;

  regFileIf regBus();

  microSequencer u_sequencer (
    .iClock     (iClock),
    .rst        (rst),
    .endFlow    (uop.endFlow),
    .flowIdx    (flowIdx),
    .mcuDataIn  (mcuDataIn),
    .upc        (upc),
    .flowActive (flowActive),
    .curOpcode  (curOpcode)
  );

  ucodeRom u_rom (
    .upc     (upc),
    .opcode  (mcuDataIn),   // Flow lookup on the fetched byte
    .uop     (uop),
    .flowIdx (flowIdx)
  );

  uopExecute u_exec (
    .iClock         (iClock),
    .rst            (rst),
    .uop            (uop),
    .flowActive     (flowActive),
    .curOpcode      (curOpcode),
    .mcuDataIn      (mcuDataIn),
    .regs           (regBus.exec),
    .mcuDataOut     (mcuDataOut),
    .mcuWe          (mcuWe),
    .mcuReadRequest (mcuReadRequest)
  );

  regFile u_regs (
    .iClock  (iClock),
    .rst     (rst),
    .regs    (regBus.regs),
    .mcuAddr (mcuAddr)
  );

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic iClock,
  output logic rst
);

  localparam int HalfPeriod = 4;   // 8 ns clock
  localparam int ResetCycles = 3;

  initial
  begin
    iClock = 1'b0;
    forever #HalfPeriod iClock = ~iClock;
  end

  // Released on a falling edge like every other DUT input
  initial
  begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge iClock);
    @(negedge iClock);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: test/gbCpuTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "gbCpu_defines.svh"

module gbCpuTb;

  localparam int NumRows = 12;
  localparam int ResetTimeout = 20;
  localparam int WriteTimeout = 100;
  localparam int IdleCycles = 200;
  localparam logic [15:0] LfsrSeed = 16'd83;
  localparam logic [1:0] StepNone = 2'd0;
  localparam logic [1:0] StepInc = 2'd1;
  localparam logic [1:0] StepDec = 2'd2;
  localparam int CarryIncRow = 9;   // Low byte forced to FF
  localparam int CarryDecRow = 10;  // Low byte forced to 00

  logic iClock;
  logic rst;
  logic [7:0] mcuDataIn;
  logic [7:0] mcuDataOut;
  logic [15:0] mcuAddr;
  logic mcuReadRequest;
  logic mcuWe;

  logic [7:0] mem [0:65535];
  logic [15:0] progPtr;
  logic [15:0] lfsrState;
  logic writeSeen;
  logic [15:0] seenAddr;
  logic [7:0] seenData;
  int valueErrors;
  int protocolErrors;
  int timeouts;

  // --------------------
  // Stimulus table with 7F as LD A,A and 78 as LD A,B
  logic [7:0] rowOp [NumRows] = '{8'hA0, 8'hA8, 8'hB0, 8'h78, 8'h7F, 8'hA0,
                                  8'hA8, 8'hB0, 8'h78, 8'hA0, 8'hB0, 8'h7F};
  logic [1:0] rowStep [NumRows] = '{StepNone, StepNone, StepNone, StepNone, StepNone, StepInc,
                                    StepDec, StepInc, StepDec, StepInc, StepDec, StepNone};
  logic [7:0] rowX [NumRows];
  logic [7:0] rowY [NumRows];
  logic [7:0] rowHi [NumRows];
  logic [7:0] rowLo [NumRows];
  logic [7:0] expData [NumRows];
  logic [15:0] expAddr [NumRows];

  clockGen u_clock (
    .iClock (iClock),
    .rst    (rst)
  );

  gbCpu u_dut (
    .iClock         (iClock),
    .rst            (rst),
    .mcuDataIn      (mcuDataIn),
    .mcuDataOut     (mcuDataOut),
    .mcuAddr        (mcuAddr),
    .mcuReadRequest (mcuReadRequest),
    .mcuWe          (mcuWe)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    lfsrStep = {state[14:0], feedback};
  endfunction

  task automatic takeBits(input int count, output logic [7:0] value);
    value = 8'h00;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[6:0], lfsrState[0]};
    end
  endtask

  function automatic logic [7:0] expectedStore(input logic [7:0] op, input logic [7:0] x,
                                               input logic [7:0] y);
    case (op)
      8'hA0:   expectedStore = x & y;
      8'hA8:   expectedStore = x ^ y;
      8'hB0:   expectedStore = x | y;
      8'h7F:   expectedStore = x;
      default: expectedStore = y;
    endcase
  endfunction

  task automatic fillTable;
    logic [7:0] bits;
    for (int i = 0; i < NumRows; i++)
    begin
      takeBits(8, bits);
      rowX[i] = bits;
      takeBits(8, bits);
      rowY[i] = bits;
      takeBits(7, bits);
      rowHi[i] = 8'h40 + bits;   // Keeps stores clear of the program
      takeBits(8, bits);
      rowLo[i] = bits;
      if (i == CarryIncRow)
        rowLo[i] = 8'hFF;
      else if (i == CarryDecRow)
        rowLo[i] = 8'h00;
      expData[i] = expectedStore(rowOp[i], rowX[i], rowY[i]);
      case (rowStep[i])
        StepInc: expAddr[i] = {rowHi[i], rowLo[i]} + 16'd1;
        StepDec: expAddr[i] = {rowHi[i], rowLo[i]} - 16'd1;
        default: expAddr[i] = {rowHi[i], rowLo[i]};
      endcase
    end
  endtask

  task automatic putByte(input logic [7:0] value);
    mem[progPtr] = value;
    progPtr = progPtr + 16'd1;
  endtask

  // --------------------
  // Program image
  task automatic buildProgram;
    logic [15:0] jpAddr;
    for (int a = 0; a < 65536; a++)
      mem[a] = a[15:8] ^ a[7:0] ^ 8'h3C;
    progPtr = `RESET_PC;
    for (int i = 0; i < NumRows; i++)
    begin
      putByte(8'h26);   // LD H,n
      putByte(rowHi[i]);
      putByte(8'h2E);   // LD L,n
      putByte(rowLo[i]);
      putByte(8'h3E);   // LD A,n
      putByte(rowX[i]);
      putByte(8'h06);   // LD B,n
      putByte(rowY[i]);
      putByte(rowOp[i]);
      if (rowStep[i] == StepInc)
        putByte(8'h23);
      else if (rowStep[i] == StepDec)
        putByte(8'h2B);
      putByte(8'h77);   // LD (HL),A
    end
    jpAddr = progPtr;
    putByte(8'hC3);
    putByte(jpAddr[7:0]);
    putByte(jpAddr[15:8]);
  endtask

  task automatic reportMismatch(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
    valueErrors++;
    $display("[FAIL] %0t ns %s got 0x%04h expected 0x%04h", $time, name, actual, expected);
  endtask

  // One bus cycle with read data from the address seen at the falling edge
  task automatic stepCycle;
    @(negedge iClock);
    if (mcuWe && mcuReadRequest)
    begin
      protocolErrors++;
      $display("Write strobe and read request were high together at %0t ns", $time);
    end
    writeSeen = 1'b0;
    if (mcuWe === 1'b1)
    begin
      mem[mcuAddr] = mcuDataOut;   // Strobe spans the whole cycle
      writeSeen = 1'b1;
      seenAddr = mcuAddr;
      seenData = mcuDataOut;
    end
    mcuDataIn = mem[mcuAddr];
  endtask

  task automatic waitForWrite(input int limit, output logic found);
    int count;
    found = 1'b0;
    count = 0;
    while (!found && count < limit)
    begin
      stepCycle();
      count++;
      found = writeSeen;
    end
  endtask

  initial
  begin
    int waitCount;
    int row;
    logic found;
    mcuDataIn = 8'h00;
    valueErrors = 0;
    protocolErrors = 0;
    timeouts = 0;
    lfsrState = LfsrSeed;
    fillTable();
    buildProgram();

    waitCount = 0;
    while (rst !== 1'b0 && waitCount < ResetTimeout)
    begin
      @(posedge iClock);
      waitCount++;
    end
    if (rst !== 1'b0)
    begin
      $display("Reset was never released");
      timeouts++;
    end
    else
    begin
      stepCycle();
      if (mcuWe !== 1'b0)
        reportMismatch("mcuWe", {15'd0, mcuWe}, 16'd0);
      if (mcuReadRequest !== 1'b0)
        reportMismatch("mcuReadRequest", {15'd0, mcuReadRequest}, 16'd0);
      if (mcuAddr !== `RESET_PC)
        reportMismatch("mcuAddr", mcuAddr, `RESET_PC);

      // --------------------
      // One store per table row
      row = 0;
      while (row < NumRows && timeouts == 0)
      begin
        waitForWrite(WriteTimeout, found);
        if (!found)
        begin
          $display("No store seen for row %0d within %0d cycles", row, WriteTimeout);
          timeouts++;
        end
        else
        begin
          if (seenAddr !== expAddr[row])
            reportMismatch("mcuAddr", seenAddr, expAddr[row]);
          if (seenData !== expData[row])
            reportMismatch("mcuDataOut", {8'h00, seenData}, {8'h00, expData[row]});
          // Read request follows the closing sma PC
          stepCycle();
          stepCycle();
          if (mcuReadRequest !== 1'b1)
            reportMismatch("mcuReadRequest", {15'd0, mcuReadRequest}, 16'd1);
        end
        row++;
      end

      // JP to itself keeps the bus quiet
      if (timeouts == 0)
      begin
        for (int c = 0; c < IdleCycles; c++)
        begin
          stepCycle();
          if (writeSeen)
          begin
            protocolErrors++;
            $display("Store to 0x%04h after the last row at %0t ns", seenAddr, $time);
          end
        end
      end
    end

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             valueErrors, protocolErrors, timeouts);
    if (valueErrors + protocolErrors + timeouts == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/cpuIsaPkg.sv
source/uopPkg.sv
source/regFileIf.sv
source/ucodeRom.sv
source/microSequencer.sv
source/regFile.sv
source/uopExecute.sv
source/gbCpu.sv
test/clockGen.sv
test/gbCpuTb.sv

// File: run.sh
#!/bin/sh
# Build the gbCpu testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module gbCpuTb -o gbCpuSim \
  && ./obj_dir/gbCpuSim | tee /dev/stderr | grep -q "^Test OK$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
